//--- Bender.yml
package:
  name: bch_syndrome

sources:
  - files:
      - design/bch_pkg.sv
      - design/gf_mult.sv
      - design/odd_syndrome_lane.sv
      - design/even_syndrome.sv
      - design/syndrome_ctrl.sv
      - design/syndrome_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_syndrome.sv

//--- design/bch_pkg.sv
package bch_pkg;

    localparam int GF_W      = 10; // widest field, GF(2^10)
    localparam int LANE_BITS = 8;  // serial bits per input byte
    localparam int CNT_W     = 8;  // byte counter, up to 128 + 3

    typedef logic [GF_W-1:0] gf_elem_t;

    typedef enum logic [1:0] {
        CODE_BCH_63   = 2'd0, // BCH(63,51), t=2
        CODE_BCH_255  = 2'd1, // BCH(255,239), t=2
        CODE_BCH_1023 = 2'd2  // BCH(1023,983), t=4
    } code_sel_e;

    typedef struct packed {
        gf_elem_t s1;
        gf_elem_t s3;
        gf_elem_t s5;
        gf_elem_t s7;
    } odd_syn_t;

    typedef struct packed {
        gf_elem_t s1;
        gf_elem_t s2;
        gf_elem_t s3;
        gf_elem_t s4;
        gf_elem_t s5;
        gf_elem_t s6;
        gf_elem_t s7;
        gf_elem_t s8;
    } syndrome_vec_t;

    function automatic logic [GF_W:0] field_poly(code_sel_e code);
        case (code)
            CODE_BCH_63:  return 11'h043; // x^6+x+1
            CODE_BCH_255: return 11'h11d; // x^8+x^4+x^3+x^2+1
            default:      return 11'h409; // x^10+x^3+1
        endcase
    endfunction

    function automatic int field_deg(code_sel_e code);
        case (code)
            CODE_BCH_63:  return 6;
            CODE_BCH_255: return 8;
            default:      return 10;
        endcase
    endfunction

    // shift-and-add, msb of b first, reduced after every shift
    function automatic gf_elem_t gf_mul_fn(gf_elem_t a, gf_elem_t b, code_sel_e code);
        logic [GF_W:0] acc;
        logic [GF_W:0] poly;
        int            deg;
        acc  = '0;
        poly = field_poly(code);
        deg  = field_deg(code);
        for (int i = GF_W - 1; i >= 0; i--) begin
            acc = acc << 1;
            if (acc[deg]) begin
                acc = acc ^ poly;
            end
            if (b[i]) begin
                acc = acc ^ {1'b0, a};
            end
        end
        return acc[GF_W-1:0];
    endfunction

    // alpha^-1 is the polynomial shifted down by one, the constant term drops out
    function automatic gf_elem_t alpha_inv_pow(code_sel_e code, int unsigned k);
        gf_elem_t inv;
        gf_elem_t acc;
        inv = gf_elem_t'(field_poly(code) >> 1);
        acc = gf_elem_t'(1);
        for (int unsigned i = 0; i < k; i++) begin
            acc = gf_mul_fn(acc, inv, code);
        end
        return acc;
    endfunction

    function automatic logic [CNT_W-1:0] bytes_per_code(code_sel_e code);
        case (code)
            CODE_BCH_63:  return 8'd8;   // 63 bits padded to 64
            CODE_BCH_255: return 8'd32;
            default:      return 8'd128;
        endcase
    endfunction

    function automatic logic [1:0] even_depth(code_sel_e code);
        return (code == CODE_BCH_1023) ? 2'd3 : 2'd2; // S8 needs a third square
    endfunction

endpackage

//--- design/even_syndrome.sv
`timescale 1ns/1ps

module even_syndrome import bch_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  code_sel_e i_code,
    input  odd_syn_t  i_odd,
    output gf_elem_t  o_s2,
    output gf_elem_t  o_s4,
    output gf_elem_t  o_s6,
    output gf_elem_t  o_s8
);

    logic     wide_code;
    gf_elem_t sq_s2;
    gf_elem_t sq_s4;
    gf_elem_t sq_s6;
    gf_elem_t sq_s8;
    gf_elem_t s2_q;
    gf_elem_t s4_q;
    gf_elem_t s6_q;
    gf_elem_t s8_q;

    assign wide_code = (i_code == CODE_BCH_1023); // only t=4 uses S6 and S8

    // S(2j) = S(j)^2 for binary codes
    gf_mult u_sq_s2 (.i_a(i_odd.s1), .i_b(i_odd.s1), .i_code(i_code), .o_product(sq_s2));
    gf_mult u_sq_s4 (.i_a(s2_q),     .i_b(s2_q),     .i_code(i_code), .o_product(sq_s4));
    gf_mult u_sq_s6 (.i_a(i_odd.s3), .i_b(i_odd.s3), .i_code(i_code), .o_product(sq_s6));
    gf_mult u_sq_s8 (.i_a(s4_q),     .i_b(s4_q),     .i_code(i_code), .o_product(sq_s8));

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            s2_q <= '0;
            s4_q <= '0;
            s6_q <= '0;
            s8_q <= '0;
        end else begin
            s2_q <= sq_s2;                     // one cycle behind S1
            s4_q <= sq_s4;                     // two cycles
            s6_q <= wide_code ? sq_s6 : '0;    // one cycle behind S3
            s8_q <= wide_code ? sq_s8 : '0;    // three cycles
        end
    end

    assign o_s2 = s2_q;
    assign o_s4 = s4_q;
    assign o_s6 = s6_q;
    assign o_s8 = s8_q;

endmodule

//--- design/gf_mult.sv
`timescale 1ns/1ps

module gf_mult import bch_pkg::*; (
    input  gf_elem_t  i_a,
    input  gf_elem_t  i_b,
    input  code_sel_e i_code,
    output gf_elem_t  o_product
);

    gf_elem_t field_mask;
    gf_elem_t a_in;
    gf_elem_t b_in;

    // smaller fields sit in the low bits
    always_comb begin
        field_mask = '0;
        for (int i = 0; i < GF_W; i++) begin
            field_mask[i] = (i < field_deg(i_code)); // bits above the degree are unused
        end
    end

    assign a_in = i_a & field_mask;
    assign b_in = i_b & field_mask;

    assign o_product = gf_mul_fn(a_in, b_in, i_code); // reduced by selected polynomial

endmodule

//--- design/odd_syndrome_lane.sv
`timescale 1ns/1ps

module odd_syndrome_lane import bch_pkg::*; #(
    parameter int SYN_IDX = 1 // odd syndrome index j
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  code_sel_e            i_code,
    input  logic                 i_clear_and_wen,
    input  logic                 i_wen,
    input  logic [LANE_BITS-1:0] i_data,
    output gf_elem_t             o_syn
);

    // alpha^(-8j) moves every power register forward by one byte
    localparam gf_elem_t STEP [4] = '{
        alpha_inv_pow(CODE_BCH_63, LANE_BITS * SYN_IDX),
        alpha_inv_pow(CODE_BCH_255, LANE_BITS * SYN_IDX),
        alpha_inv_pow(CODE_BCH_1023, LANE_BITS * SYN_IDX),
        '0 // reserved code
    };

    logic     lane_on;
    logic     pow_nz;
    gf_elem_t acc_q;
    gf_elem_t first_sum;
    gf_elem_t next_sum;
    gf_elem_t pow_q      [LANE_BITS];
    gf_elem_t pow_step   [LANE_BITS];
    gf_elem_t init_pow   [LANE_BITS];
    gf_elem_t first_term [LANE_BITS];
    gf_elem_t next_term  [LANE_BITS];

    assign lane_on = (SYN_IDX <= 3) || (i_code == CODE_BCH_1023); // t=2 codes stop at S3

    for (genvar i = 0; i < LANE_BITS; i++) begin : g_bit
        localparam int N_FIRST = SYN_IDX * i;
        localparam int N_INIT  = SYN_IDX * (LANE_BITS + i);
        localparam gf_elem_t FIRST [4] = '{
            alpha_inv_pow(CODE_BCH_63, N_FIRST),
            alpha_inv_pow(CODE_BCH_255, N_FIRST),
            alpha_inv_pow(CODE_BCH_1023, N_FIRST),
            '0
        };
        localparam gf_elem_t INIT [4] = '{
            alpha_inv_pow(CODE_BCH_63, N_INIT),
            alpha_inv_pow(CODE_BCH_255, N_INIT),
            alpha_inv_pow(CODE_BCH_1023, N_INIT),
            '0
        };

        logic bit_r;

        assign bit_r         = i_data[LANE_BITS-1-i]; // msb arrives first
        assign first_term[i] = FIRST[i_code] & {GF_W{bit_r}};
        assign next_term[i]  = pow_q[i] & {GF_W{bit_r}};
        assign init_pow[i]   = INIT[i_code];

        gf_mult u_step (
            .i_a       (pow_q[i]),
            .i_b       (STEP[i_code]),
            .i_code    (i_code),
            .o_product (pow_step[i])
        );
    end

    always_comb begin
        first_sum = '0;
        next_sum  = '0;
        pow_nz    = 1'b1;
        for (int k = 0; k < LANE_BITS; k++) begin
            first_sum = first_sum ^ first_term[k];
            next_sum  = next_sum ^ next_term[k];
            pow_nz    = pow_nz & (pow_q[k] != '0);
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            acc_q <= '0;
            for (int k = 0; k < LANE_BITS; k++) begin
                pow_q[k] <= '0;
            end
        end else if (i_clear_and_wen) begin
            acc_q <= lane_on ? first_sum : '0; // first byte starts a new frame
            for (int k = 0; k < LANE_BITS; k++) begin
                pow_q[k] <= lane_on ? init_pow[k] : '0;
            end
        end else if (i_wen && lane_on) begin
            acc_q <= acc_q ^ next_sum;
            for (int k = 0; k < LANE_BITS; k++) begin
                pow_q[k] <= pow_step[k];
            end
        end
    end

    assign o_syn = acc_q;

    // a zero power would silently drop bits for the rest of the frame
    a_pow_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_clear_and_wen && lane_on) |=> (pow_nz until_with i_clear_and_wen))
        else $error("lane S%0d: power register reached zero", SYN_IDX);

endmodule

//--- design/syndrome_ctrl.sv
`timescale 1ns/1ps

module syndrome_ctrl import bch_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  code_sel_e i_code,
    input  logic      i_clear_and_wen,
    input  logic      i_wen,
    output logic      o_odd_valid,
    output logic      o_all_valid
);

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] odd_cnt;
    logic [CNT_W-1:0] all_cnt;

    assign odd_cnt = bytes_per_code(i_code);
    assign all_cnt = odd_cnt + {{(CNT_W-2){1'b0}}, even_depth(i_code)}; // saturation point

    // counts bytes, then keeps counting while the squaring stage settles
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (i_clear_and_wen) begin
            cnt_q <= {{(CNT_W-1){1'b0}}, 1'b1}; // first byte taken
        end else if (cnt_q >= odd_cnt) begin
            if (cnt_q < all_cnt) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else if (i_wen) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_comb begin
        o_odd_valid = (cnt_q >= odd_cnt) && !i_clear_and_wen;
        o_all_valid = (cnt_q >= all_cnt) && !i_clear_and_wen;
    end

    a_code_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_code inside {CODE_BCH_63, CODE_BCH_255, CODE_BCH_1023})
        else $error("reserved value on i_code");

    // a frame carries exactly bytes_per_code bytes
    a_no_extra_byte: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wen && !i_clear_and_wen) |-> (cnt_q < odd_cnt))
        else $error("byte written after the end of the frame");

endmodule

//--- design/syndrome_top.sv
`timescale 1ns/1ps

module syndrome_top import bch_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  code_sel_e            i_code,
    input  logic                 i_clear_and_wen,
    input  logic                 i_wen,
    input  logic [LANE_BITS-1:0] i_data,
    output syndrome_vec_t        o_syndromes,
    output logic                 o_odd_valid,
    output logic                 o_all_valid
);

    odd_syn_t odd_syn;
    gf_elem_t s1;
    gf_elem_t s2;
    gf_elem_t s3;
    gf_elem_t s4;
    gf_elem_t s5;
    gf_elem_t s6;
    gf_elem_t s7;
    gf_elem_t s8;

    odd_syndrome_lane #(.SYN_IDX(1)) u_lane_s1 (
        .i_clk, .i_rst_n, .i_code, .i_clear_and_wen, .i_wen, .i_data,
        .o_syn (s1)
    );

    odd_syndrome_lane #(.SYN_IDX(3)) u_lane_s3 (
        .i_clk, .i_rst_n, .i_code, .i_clear_and_wen, .i_wen, .i_data,
        .o_syn (s3)
    );

    odd_syndrome_lane #(.SYN_IDX(5)) u_lane_s5 (
        .i_clk, .i_rst_n, .i_code, .i_clear_and_wen, .i_wen, .i_data,
        .o_syn (s5)
    );

    odd_syndrome_lane #(.SYN_IDX(7)) u_lane_s7 (
        .i_clk, .i_rst_n, .i_code, .i_clear_and_wen, .i_wen, .i_data,
        .o_syn (s7)
    );

    assign odd_syn = '{s1: s1, s3: s3, s5: s5, s7: s7};

    even_syndrome u_even (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_code  (i_code),
        .i_odd   (odd_syn),
        .o_s2    (s2),
        .o_s4    (s4),
        .o_s6    (s6),
        .o_s8    (s8)
    );

    syndrome_ctrl u_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_code          (i_code),
        .i_clear_and_wen (i_clear_and_wen),
        .i_wen           (i_wen),
        .o_odd_valid     (o_odd_valid),
        .o_all_valid     (o_all_valid)
    );

    assign o_syndromes = '{
        s1: odd_syn.s1, s2: s2,
        s3: odd_syn.s3, s4: s4,
        s5: odd_syn.s5, s6: s6,
        s7: odd_syn.s7, s8: s8
    };

endmodule

//--- files.f
+incdir+tb
design/bch_pkg.sv
design/gf_mult.sv
design/odd_syndrome_lane.sv
design/even_syndrome.sv
design/syndrome_ctrl.sv
design/syndrome_top.sv
tb/tb_syndrome.sv

//--- tb/bch_ref_model.svh
`ifndef BCH_REF_MODEL_SVH
`define BCH_REF_MODEL_SVH

function automatic logic [10:0] ref_poly(code_sel_e c);
    case (c)
        CODE_BCH_63:  return 11'h043; // x^6+x+1
        CODE_BCH_255: return 11'h11d; // x^8+x^4+x^3+x^2+1
        default:      return 11'h409; // x^10+x^3+1
    endcase
endfunction

// x * alpha^-1, clear the constant term with the polynomial then shift down
function automatic gf_elem_t div_alpha(gf_elem_t x, logic [10:0] poly);
    logic [10:0] t;
    t = {1'b0, x};
    if (t[0]) begin
        t = t ^ poly;
    end
    t = t >> 1;
    return t[9:0];
endfunction

// S_j = xor of r_n * alpha^(-j*n), one bit at a time from frame_bytes
function automatic gf_elem_t serial_syndrome(code_sel_e c, int j, int nbytes);
    logic [10:0] poly;
    gf_elem_t    pw;
    gf_elem_t    s;
    poly = ref_poly(c);
    pw   = gf_elem_t'(1);
    s    = '0;
    for (int n = 0; n < nbytes * 8; n++) begin
        if (frame_bytes[n / 8][7 - (n % 8)]) begin
            s = s ^ pw;
        end
        for (int k = 0; k < j; k++) begin
            pw = div_alpha(pw, poly);
        end
    end
    return s;
endfunction

function automatic syndrome_vec_t ref_syndromes(code_sel_e c, int nbytes);
    syndrome_vec_t v;
    v = '0;
    v.s1 = serial_syndrome(c, 1, nbytes);
    v.s2 = serial_syndrome(c, 2, nbytes);
    v.s3 = serial_syndrome(c, 3, nbytes);
    v.s4 = serial_syndrome(c, 4, nbytes);
    if (c == CODE_BCH_1023) begin // t=2 codes leave S5 to S8 at zero
        v.s5 = serial_syndrome(c, 5, nbytes);
        v.s6 = serial_syndrome(c, 6, nbytes);
        v.s7 = serial_syndrome(c, 7, nbytes);
        v.s8 = serial_syndrome(c, 8, nbytes);
    end
    return v;
endfunction

`endif

//--- tb/tb_syndrome.sv
`timescale 1ns/1ps

module tb_syndrome import bch_pkg::*; ();

    localparam int NUM_FRAMES = 6;
    localparam int MAX_BYTES  = 128;
    localparam int MAX_GAP    = 3;
    localparam int MAX_CYCLES = NUM_FRAMES * MAX_BYTES * (MAX_GAP + 1) + 928; // 4000

    logic          clk           = 1'b0;
    logic          rst_n         = 1'b0;
    code_sel_e     code          = CODE_BCH_63;
    logic          clear_and_wen = 1'b0;
    logic          wen           = 1'b0;
    logic [7:0]    data          = 8'h00;
    logic          in_frame      = 1'b0; // clear cycle through last byte cycle
    logic          last_byte     = 1'b0;
    logic          all_seen      = 1'b0;
    int            cyc           = 0;
    int            value_errors  = 0;
    int            timing_errors = 0;
    int            frames_checked = 0;
    integer        seed;
    logic [7:0]    frame_bytes [MAX_BYTES];
    syndrome_vec_t expected;
    syndrome_vec_t syndromes;
    logic          odd_valid;
    logic          all_valid;

    `include "bch_ref_model.svh"

    syndrome_top UUT (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_code          (code),
        .i_clear_and_wen (clear_and_wen),
        .i_wen           (wen),
        .i_data          (data),
        .o_syndromes     (syndromes),
        .o_odd_valid     (odd_valid),
        .o_all_valid     (all_valid)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles before all frames were sent", cyc);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    always @(negedge clk) begin
        all_seen <= all_valid;
        if (all_valid && !all_seen) begin
            frames_checked <= frames_checked + 1; // one rise per frame
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        (cyc >= 1 && cyc <= 17) |-> (!odd_valid && !all_valid && syndromes == '0))
        else begin
            timing_errors = timing_errors + 1;
            $display("Fail %0t: outputs not idle around reset", $time);
        end

    a_odd_on_time: assert property (@(posedge clk) disable iff (!rst_n)
        last_byte |=> odd_valid)
        else begin
            timing_errors = timing_errors + 1;
            $display("Fail %0t: odd_valid missing after last byte", $time);
        end

    a_odd_not_early: assert property (@(posedge clk) disable iff (!rst_n)
        in_frame |-> !odd_valid)
        else begin
            timing_errors = timing_errors + 1;
            $display("Fail %0t: odd_valid high before last byte taken", $time);
        end

    a_odd_match: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(odd_valid) |-> (syndromes.s1 == expected.s1 && syndromes.s3 == expected.s3 &&
                              syndromes.s5 == expected.s5 && syndromes.s7 == expected.s7))
        else begin
            value_errors = value_errors + 1;
            $display("Fail %0t: odd syndromes got %h expected %h", $time,
                     $sampled(syndromes), expected);
        end

    a_all_delay_t2: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(odd_valid) && code != CODE_BCH_1023) |->
            !all_valid ##1 !all_valid ##1 all_valid)
        else begin
            timing_errors = timing_errors + 1;
            $display("Fail %0t: all_valid not two cycles after odd_valid", $time);
        end

    a_all_delay_t4: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(odd_valid) && code == CODE_BCH_1023) |->
            !all_valid ##1 !all_valid ##1 !all_valid ##1 all_valid)
        else begin
            timing_errors = timing_errors + 1;
            $display("Fail %0t: all_valid not three cycles after odd_valid", $time);
        end

    a_all_match: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(all_valid) |-> (syndromes == expected))
        else begin
            value_errors = value_errors + 1;
            $display("Fail %0t: syndromes got %h expected %h", $time,
                     $sampled(syndromes), expected);
        end

    a_clear_drops: assert property (@(posedge clk) disable iff (!rst_n)
        clear_and_wen |-> (!odd_valid && !all_valid))
        else begin
            timing_errors = timing_errors + 1;
            $display("Fail %0t: flags high during clear pulse", $time);
        end

    function automatic int frame_len(code_sel_e c);
        case (c)
            CODE_BCH_63:  return 8;
            CODE_BCH_255: return 32;
            default:      return 128;
        endcase
    endfunction

    task automatic make_frame(input code_sel_e c, input logic zero_fill);
        logic [31:0] rnd;
        for (int k = 0; k < frame_len(c); k++) begin
            rnd = $random(seed);
            frame_bytes[k] = zero_fill ? 8'h00 : rnd[7:0];
        end
        expected = ref_syndromes(c, frame_len(c));
    endtask

    task automatic send_frame(input code_sel_e c, input logic with_gaps);
        logic [31:0] rnd;
        int          gap;
        @(posedge clk);
        code          <= c;
        clear_and_wen <= 1'b1; // carries byte 0
        data          <= frame_bytes[0];
        in_frame      <= 1'b1;
        for (int k = 1; k < frame_len(c); k++) begin
            gap = 0;
            if (with_gaps) begin
                rnd = $random(seed);
                gap = int'(rnd[1:0]);
            end
            repeat (gap) begin
                @(posedge clk);
                clear_and_wen <= 1'b0;
                wen           <= 1'b0;
            end
            @(posedge clk);
            clear_and_wen <= 1'b0;
            wen           <= 1'b1;
            data          <= frame_bytes[k];
            last_byte     <= (k == frame_len(c) - 1);
        end
        @(posedge clk);
        wen       <= 1'b0;
        last_byte <= 1'b0;
        in_frame  <= 1'b0;
    endtask

    task automatic run_frame(input code_sel_e c, input logic zero_fill, input logic with_gaps);
        make_frame(c, zero_fill);
        send_frame(c, with_gaps);
        do begin
            @(negedge clk);
        end while (!all_valid); // global cycle limit catches a stall
        @(posedge clk); // final compare samples expected on this edge
    endtask

    initial begin
        seed = 32'h00596dc0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        run_frame(CODE_BCH_63, 1'b0, 1'b0);
        run_frame(CODE_BCH_255, 1'b0, 1'b0); // each later clear lands with all_valid high
        run_frame(CODE_BCH_1023, 1'b0, 1'b0);
        run_frame(CODE_BCH_1023, 1'b0, 1'b1); // random gaps between bytes
        run_frame(CODE_BCH_255, 1'b1, 1'b0);  // all-zero frame
        run_frame(CODE_BCH_63, 1'b0, 1'b0);
        repeat (4) @(posedge clk);
        if (frames_checked != NUM_FRAMES) begin
            $display("only %0d of %0d frames reached the final check", frames_checked,
                     NUM_FRAMES);
        end
        $display("value errors: %0d, timing errors: %0d, frames checked: %0d",
                 value_errors, timing_errors, frames_checked);
        if (value_errors == 0 && timing_errors == 0 && frames_checked == NUM_FRAMES) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
